// File: hw/x87_pkg.sv
package x87_pkg;

    // ------------------------------------------------------------------------
    // Data words
    // ------------------------------------------------------------------------
    typedef logic [63:0] fp64_t;
    typedef logic [31:0] fp32_t;
    typedef logic [15:0] x87_word_t;

    // Command codes as delivered by the decoder
    typedef enum logic [4:0] {
        CMD_NOP       = 5'd0,
        CMD_FNSTSW_AX = 5'd1,
        CMD_FNINIT    = 5'd2,
        CMD_FLDCW     = 5'd3,
        CMD_FNSTCW    = 5'd4,
        CMD_FWAIT     = 5'd5,
        CMD_FLD_M32   = 5'd6,
        CMD_FLD_M64   = 5'd7,
        CMD_FSTP_M32  = 5'd8,
        CMD_FSTP_M64  = 5'd9,
        CMD_FLD_STI   = 5'd10,
        CMD_FXCH_STI  = 5'd11,
        CMD_FSTP_STI  = 5'd12,
        CMD_FCOMPP    = 5'd16,
        CMD_FCOM_STI  = 5'd23,
        CMD_FCOMP_STI = 5'd26
    } x87_cmd_e;

    typedef enum logic [1:0] {
        SIZE16 = 2'd0,
        SIZE32 = 2'd1,
        SIZE64 = 2'd2
    } store_size_e;

    typedef enum logic [2:0] {
        WB_NONE = 3'd0,
        WB_AX   = 3'd1
    } wb_kind_e;

    // ------------------------------------------------------------------------
    // Structures passed between the blocks
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic       valid;
        x87_cmd_e   op;
        logic [2:0] idx;
        logic       step_hi;
        fp64_t      load_value;   // already widened to binary64
        x87_word_t  cw_value;
    } x87_req_t;

    typedef struct packed {
        logic        valid;
        store_size_e size;
        fp64_t       data;
    } x87_mem_store_t;

    typedef struct packed {
        logic      valid;
        wb_kind_e  kind;
        x87_word_t value;
    } x87_wb_t;

    // Control word after reset and FNINIT
    localparam x87_word_t FCW_RESET = 16'h037F;

endpackage

// File: hw/x87_request_in.sv
`timescale 1ns/10ps

module x87_request_in
    import x87_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       cmd_valid,
    input  x87_cmd_e   cmd,
    input  logic [2:0] idx,
    input  logic [3:0] step,
    input  fp32_t      mem_rdata32,
    input  fp64_t      mem_rdata64,
    output x87_req_t   req
);

    // Widen binary32 to binary64
    // Zero and denormals keep only the sign, Inf and NaN become +0
    function automatic fp64_t f32_to_f64(input fp32_t f);
        logic [10:0] exp64;
        exp64 = {3'b000, f[30:23]} + 11'd896;
        if (f[30:23] == 8'h00) begin
            return {f[31], 63'd0};
        end else if (f[30:23] == 8'hFF) begin
            return '0;
        end else begin
            return {f[31], exp64, f[22:0], 29'd0};
        end
    endfunction

    fp64_t load_value;

    always_comb begin
        if (cmd == CMD_FLD_M32) begin
            load_value = f32_to_f64(mem_rdata32);
        end else begin
            load_value = mem_rdata64;
        end
    end

    // A request exists only when both strobes are high
    always_comb begin
        req.valid      = start && cmd_valid;
        req.op         = cmd;
        req.idx        = idx;
        req.step_hi    = step[0];
        req.load_value = load_value;
        req.cw_value   = mem_rdata32[15:0];
    end

    // The downstream case statements rely on a clean opcode
    a_cmd_known: assert property (
        @(posedge clk) disable iff (rst) req.valid |-> !$isunknown(cmd)
    ) else $error("x87 command has unknown bits while accepted");

endmodule

// File: hw/x87_reg_stack.sv
`timescale 1ns/10ps

module x87_reg_stack
    import x87_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  x87_req_t req,
    output fp64_t    st0,
    output fp64_t    sti
);

    fp64_t      st [0:7];
    x87_word_t  ftw;
    logic [2:0] top;

    logic [2:0] rd_idx;
    logic [2:0] phys_0;
    logic [2:0] phys_i;
    logic [2:0] phys_push;

    logic       push_en;
    fp64_t      push_value;
    logic [1:0] push_tag;
    logic [1:0] pop_cnt;

    // FCOMPP always works on ST0 and ST1
    assign rd_idx    = (req.op == CMD_FCOMPP) ? 3'd1 : req.idx;
    assign phys_0    = top;
    assign phys_i    = top + rd_idx;
    assign phys_push = top - 3'd1;

    assign st0 = st[phys_0];
    assign sti = st[phys_i];

    // ------------------------------------------------------------------------
    // Command decode into push / pop
    // ------------------------------------------------------------------------
    always_comb begin
        push_en    = 1'b0;
        push_value = req.load_value;
        push_tag   = 2'b00;
        pop_cnt    = 2'd0;
        if (req.valid) begin
            case (req.op)
                CMD_FLD_M32, CMD_FLD_M64: begin
                    push_en = 1'b1;
                end
                CMD_FLD_STI: begin
                    push_en    = 1'b1;
                    push_value = sti;
                    push_tag   = ftw[{phys_i, 1'b0} +: 2];
                end
                CMD_FSTP_M32, CMD_FSTP_STI, CMD_FCOMP_STI: begin
                    pop_cnt = 2'd1;
                end
                CMD_FSTP_M64: begin
                    // Pop only on the second half of the store
                    pop_cnt = req.step_hi ? 2'd1 : 2'd0;
                end
                CMD_FCOMPP: begin
                    pop_cnt = 2'd2;
                end
                default: begin
                end
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push_en) begin
            st[phys_push] <= push_value;
        end else if (req.valid && req.op == CMD_FXCH_STI) begin
            st[phys_0] <= sti;
            st[phys_i] <= st0;
        end else if (req.valid && req.op == CMD_FSTP_STI) begin
            st[phys_i] <= st0;
        end
    end

    // Tags and top pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            ftw <= 16'hFFFF;
            top <= 3'd0;
        end else if (req.valid) begin
            if (req.op == CMD_FNINIT) begin
                ftw <= 16'hFFFF;
                top <= 3'd0;
            end else if (push_en) begin
                ftw[{phys_push, 1'b0} +: 2] <= push_tag;
                top <= phys_push;
            end else begin
                if (req.op == CMD_FSTP_STI) begin
                    ftw[{phys_i, 1'b0} +: 2] <= ftw[{phys_0, 1'b0} +: 2];
                end
                // Later writes win, so ST0 ends up empty even for FSTP ST(0)
                if (pop_cnt != 2'd0) begin
                    ftw[{phys_0, 1'b0} +: 2] <= 2'b11;
                end
                if (pop_cnt == 2'd2) begin
                    ftw[{phys_i, 1'b0} +: 2] <= 2'b11;
                end
                top <= top + {1'b0, pop_cnt};
            end
        end
    end

    a_top_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(top)
    ) else $error("x87 stack top is unknown");

endmodule

// File: hw/x87_control_regs.sv
`timescale 1ns/10ps

module x87_control_regs
    import x87_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  x87_req_t  req,
    input  fp64_t     st0,
    input  fp64_t     sti,
    output x87_word_t fcw,
    output x87_word_t fsw
);

    logic [62:0] mag_a;
    logic [62:0] mag_b;
    logic        cmp_lt;
    logic        cmp_eq;
    logic        is_compare;

    assign mag_a = st0[62:0];
    assign mag_b = sti[62:0];

    // Sign-magnitude compare of ST0 against ST(i)
    always_comb begin
        if (mag_a == '0 && mag_b == '0) begin
            // +0 and -0 are equal
            cmp_lt = 1'b0;
            cmp_eq = 1'b1;
        end else if (st0[63] != sti[63]) begin
            cmp_lt = st0[63];
            cmp_eq = 1'b0;
        end else begin
            cmp_eq = (mag_a == mag_b);
            cmp_lt = st0[63] ? (mag_a > mag_b) : (mag_a < mag_b);
        end
    end

    assign is_compare = (req.op == CMD_FCOM_STI) || (req.op == CMD_FCOMP_STI) ||
                        (req.op == CMD_FCOMPP);

    always_ff @(posedge clk) begin
        if (rst) begin
            fcw <= FCW_RESET;
            fsw <= '0;
        end else if (req.valid) begin
            if (req.op == CMD_FNINIT) begin
                fcw <= FCW_RESET;
                fsw <= '0;
            end else if (req.op == CMD_FLDCW) begin
                fcw <= req.cw_value;
            end else if (is_compare) begin
                // C0, C2, C3
                fsw[8]  <= cmp_lt;
                fsw[10] <= 1'b0;
                fsw[14] <= cmp_eq;
            end
        end
    end

endmodule

// File: hw/x87_store_out.sv
`timescale 1ns/10ps

module x87_store_out
    import x87_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  x87_req_t       req,
    input  fp64_t          st0,
    input  x87_word_t      fcw,
    input  x87_word_t      fsw,
    output x87_mem_store_t memstore,
    output x87_wb_t        wb,
    output logic           done
);

    // Narrow binary64 to binary32 by truncation
    function automatic fp32_t f64_to_f32(input fp64_t d);
        logic [10:0] exp_reb;
        exp_reb = d[62:52] - 11'd896;
        if (d[62:52] == 11'd0) begin
            return {d[63], 31'd0};
        end else if (d[62:52] == 11'h7FF) begin
            return '0;
        end else if (d[62:52] < 11'd896 || d[62:52] > 11'd1151) begin
            return '0;
        end else begin
            return {d[63], exp_reb[7:0], d[51:29]};
        end
    endfunction

    fp64_t latch_data;
    logic  latch_valid;
    logic  fstp64_lo;
    logic  fstp64_hi;

    assign fstp64_lo = req.valid && req.op == CMD_FSTP_M64 && !req.step_hi;
    assign fstp64_hi = req.valid && req.op == CMD_FSTP_M64 && req.step_hi;

    always_ff @(posedge clk) begin
        if (fstp64_lo) begin
            latch_data <= st0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memstore    <= '0;
            wb          <= '0;
            done        <= 1'b0;
            latch_valid <= 1'b0;
        end else begin
            memstore <= '0;
            wb       <= '0;
            done     <= req.valid;
            if (req.valid) begin
                case (req.op)
                    CMD_FNSTCW:    memstore <= '{1'b1, SIZE16, {48'd0, fcw}};
                    CMD_FSTP_M32:  memstore <= '{1'b1, SIZE32, {32'd0, f64_to_f32(st0)}};
                    CMD_FNSTSW_AX: wb <= '{1'b1, WB_AX, fsw};
                    CMD_FNINIT:    latch_valid <= 1'b0;
                    CMD_FSTP_M64: begin
                        if (req.step_hi) begin
                            memstore    <= '{latch_valid, SIZE64, latch_data};
                            latch_valid <= 1'b0;
                        end else begin
                            memstore    <= '{1'b1, SIZE64, st0};
                            latch_valid <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Second half must follow a first half with no FNINIT in between
    a_latch_ready: assert property (
        @(posedge clk) disable iff (rst) fstp64_hi |-> latch_valid
    ) else $error("FSTP m64 step 1 without a latched value");

endmodule

// File: hw/x87_exec.sv
`timescale 1ns/10ps

module x87_exec
    import x87_pkg::*;
(
    input  logic           clk,
    input  logic           rst,

    input  logic           start,
    input  x87_cmd_e       cmd,
    input  logic           cmd_valid,
    input  logic [2:0]     idx,
    input  logic [3:0]     step,

    input  fp32_t          mem_rdata32,
    input  fp64_t          mem_rdata64,

    output x87_mem_store_t memstore,
    output logic           done,
    output x87_wb_t        wb
);

    x87_req_t  req;
    fp64_t     st0;
    fp64_t     sti;
    x87_word_t fcw;
    x87_word_t fsw;

    // ------------------------------------------------------------------------
    // Request capture, state, results
    // ------------------------------------------------------------------------
    x87_request_in request_in_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .idx         (idx),
        .step        (step),
        .mem_rdata32 (mem_rdata32),
        .mem_rdata64 (mem_rdata64),
        .req         (req)
    );

    x87_reg_stack reg_stack_i (
        .clk (clk),
        .rst (rst),
        .req (req),
        .st0 (st0),
        .sti (sti)
    );

    x87_control_regs control_regs_i (
        .clk (clk),
        .rst (rst),
        .req (req),
        .st0 (st0),
        .sti (sti),
        .fcw (fcw),
        .fsw (fsw)
    );

    x87_store_out store_out_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .st0      (st0),
        .fcw      (fcw),
        .fsw      (fsw),
        .memstore (memstore),
        .wb       (wb),
        .done     (done)
    );

endmodule

// File: testbench/tb_x87_table.svh
task automatic build_table();
    // Each row gives command, idx, step, mem_rdata32, mem_rdata64, expected kind and value
    // Reset values, control word, FWAIT and FNINIT
    add_row(CMD_FNSTCW,    0, 0, 32'h0000_0000, 64'h0, E_S16, 64'h037F);
    add_row(CMD_FNSTSW_AX, 0, 0, 32'h0000_0000, 64'h0, E_WB,  64'h0000);
    add_row(CMD_FLDCW,     0, 0, 32'h0000_027F, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FNSTCW,    0, 0, 32'h0000_0000, 64'h0, E_S16, 64'h027F);
    add_row(CMD_FWAIT,     0, 0, 32'h0000_0000, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FNINIT,    0, 0, 32'h0000_0000, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FNSTCW,    0, 0, 32'h0000_0000, 64'h0, E_S16, 64'h037F);
    add_row(CMD_FNSTSW_AX, 0, 0, 32'h0000_0000, 64'h0, E_WB,  64'h0000);
    // Three loads come back in reverse order
    add_row(CMD_FLD_M64,  0, 0, 32'h0, 64'h3FF0_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FLD_M64,  0, 0, 32'h0, 64'h4000_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FLD_M64,  0, 0, 32'h0, 64'h4008_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FSTP_M64, 0, 0, 32'h0, 64'h0, E_S64, 64'h4008_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 1, 32'h0, 64'h0, E_S64, 64'h4008_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 0, 32'h0, 64'h0, E_S64, 64'h4000_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 1, 32'h0, 64'h0, E_S64, 64'h4000_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 0, 32'h0, 64'h0, E_S64, 64'h3FF0_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 1, 32'h0, 64'h0, E_S64, 64'h3FF0_0000_0000_0000);
    // m32 round trip with a normal, a negative denormal, Inf and NaN
    add_row(CMD_FLD_M32,  0, 0, 32'h3FC0_0000, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FSTP_M32, 0, 0, 32'h0000_0000, 64'h0, E_S32, 64'h3FC0_0000);
    add_row(CMD_FLD_M32,  0, 0, 32'h8040_0000, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FSTP_M32, 0, 0, 32'h0000_0000, 64'h0, E_S32, 64'h8000_0000);
    add_row(CMD_FLD_M32,  0, 0, 32'h7F80_0000, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FSTP_M32, 0, 0, 32'h0000_0000, 64'h0, E_S32, 64'h0000_0000);
    add_row(CMD_FLD_M32,  0, 0, 32'hFFC0_0000, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FSTP_M32, 0, 0, 32'h0000_0000, 64'h0, E_S32, 64'h0000_0000);
    // Stack is A=4, B=5, C=6 pushed in order, then [C B A] -> [B C B A] -> [C B B A] -> [B C A]
    add_row(CMD_FLD_M64,  0, 0, 32'h0, 64'h4010_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FLD_M64,  0, 0, 32'h0, 64'h4014_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FLD_M64,  0, 0, 32'h0, 64'h4018_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FLD_STI,  1, 0, 32'h0, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FXCH_STI, 1, 0, 32'h0, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FSTP_STI, 2, 0, 32'h0, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FSTP_M64, 0, 0, 32'h0, 64'h0, E_S64, 64'h4014_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 1, 32'h0, 64'h0, E_S64, 64'h4014_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 0, 32'h0, 64'h0, E_S64, 64'h4018_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 1, 32'h0, 64'h0, E_S64, 64'h4018_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 0, 32'h0, 64'h0, E_S64, 64'h4010_0000_0000_0000);
    add_row(CMD_FSTP_M64, 0, 1, 32'h0, 64'h0, E_S64, 64'h4010_0000_0000_0000);
    // 1 < 2 sets C0, then 2 > 1 clears it and FCOMP leaves 1.0 on top
    add_row(CMD_FLD_M64,   0, 0, 32'h0, 64'h4000_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FLD_M64,   0, 0, 32'h0, 64'h3FF0_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FCOM_STI,  1, 0, 32'h0, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FNSTSW_AX, 0, 0, 32'h0, 64'h0, E_WB, 64'h0100);
    add_row(CMD_FXCH_STI,  1, 0, 32'h0, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FCOMP_STI, 1, 0, 32'h0, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FNSTSW_AX, 0, 0, 32'h0, 64'h0, E_WB, 64'h0000);
    add_row(CMD_FSTP_M64,  0, 0, 32'h0, 64'h0, E_S64, 64'h3FF0_0000_0000_0000);
    add_row(CMD_FSTP_M64,  0, 1, 32'h0, 64'h0, E_S64, 64'h3FF0_0000_0000_0000);
    // -0 equals +0, and FCOMPP pops both down to the -1.5 below them
    // FCOMPP ignores idx and always takes ST(1)
    add_row(CMD_FLD_M64,   0, 0, 32'h0, 64'hBFF8_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FLD_M64,   0, 0, 32'h0, 64'h0000_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FLD_M64,   0, 0, 32'h0, 64'h8000_0000_0000_0000, E_NONE, 64'h0);
    add_row(CMD_FCOMPP,    2, 0, 32'h0, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FNSTSW_AX, 0, 0, 32'h0, 64'h0, E_WB, 64'h4000);
    add_row(CMD_FSTP_M64,  0, 0, 32'h0, 64'h0, E_S64, 64'hBFF8_0000_0000_0000);
    add_row(CMD_FSTP_M64,  0, 1, 32'h0, 64'h0, E_S64, 64'hBFF8_0000_0000_0000);
    // FNINIT clears the condition codes left by FCOMPP
    add_row(CMD_FNINIT,    0, 0, 32'h0, 64'h0, E_NONE, 64'h0);
    add_row(CMD_FNSTSW_AX, 0, 0, 32'h0, 64'h0, E_WB, 64'h0000);
endtask

// File: testbench/tb_x87_exec.sv
`timescale 1ns/10ps

module tb_x87_exec
    import x87_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20;

    // Which result a row expects, and of what store size
    typedef enum logic [2:0] {
        E_NONE,
        E_S16,
        E_S32,
        E_S64,
        E_WB
    } expect_e;

    typedef struct packed {
        x87_cmd_e   cmd;
        logic [2:0] idx;
        logic [3:0] step;
        fp32_t      r32;
        fp64_t      r64;
        expect_e    kind;
        fp64_t      value;
    } row_t;

    logic           clk;
    logic           rst;
    logic           start;
    logic           cmd_valid;
    x87_cmd_e       cmd;
    logic [2:0]     idx;
    logic [3:0]     step;
    fp32_t          mem_rdata32;
    fp64_t          mem_rdata64;
    x87_mem_store_t memstore;
    logic           done;
    x87_wb_t        wb;

    row_t rows[$];

    x87_exec dut_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .idx         (idx),
        .step        (step),
        .mem_rdata32 (mem_rdata32),
        .mem_rdata64 (mem_rdata64),
        .memstore    (memstore),
        .done        (done),
        .wb          (wb)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------------------
    function automatic void add_row(input x87_cmd_e c, input int i, input int s,
                                    input fp32_t r32, input fp64_t r64,
                                    input expect_e k, input fp64_t v);
        row_t r;
        r = '{c, 3'(i), 4'(s), r32, r64, k, v};
        rows.push_back(r);
    endfunction

    `include "tb_x87_table.svh"

    // ------------------------------------------------------------------------
    // Stop and compare helpers
    // ------------------------------------------------------------------------
    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "x87 testbench stopped at the first error");
    endtask

    task automatic check_store(input x87_mem_store_t got, input x87_mem_store_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: memstore got %b/%0d/%h, expected %b/%0d/%h",
                     $time, got.valid, got.size, got.data, exp.valid, exp.size, exp.data);
            abort_run();
        end
    endtask

    task automatic check_wb(input x87_wb_t got, input x87_wb_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: wb got valid=%b kind=%0d value=%h, expected %b %0d %h",
                     $time, got.valid, got.kind, got.value, exp.valid, exp.kind, exp.value);
            abort_run();
        end
    endtask

    // Drive one request and wait for its done pulse
    task automatic apply_row(input row_t r);
        int waited;
        @(posedge clk);
        start       <= 1'b1;
        cmd_valid   <= 1'b1;
        cmd         <= r.cmd;
        idx         <= r.idx;
        step        <= r.step;
        mem_rdata32 <= r.r32;
        mem_rdata64 <= r.r64;
        // Request is taken on this edge
        @(posedge clk);
        start     <= 1'b0;
        cmd_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!done && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        if (!done) begin
            $display("The done pulse never arrived for command code %0d", r.cmd);
            abort_run();
        end
    endtask

    task automatic expect_results(input row_t r);
        x87_mem_store_t exp_store;
        x87_wb_t        exp_wb;
        exp_store = '0;
        exp_wb    = '0;
        case (r.kind)
            E_S16: exp_store = '{1'b1, SIZE16, r.value};
            E_S32: exp_store = '{1'b1, SIZE32, r.value};
            E_S64: exp_store = '{1'b1, SIZE64, r.value};
            E_WB:  exp_wb    = '{1'b1, WB_AX, r.value[15:0]};
            default: begin
            end
        endcase
        check_store(memstore, exp_store);
        check_wb(wb, exp_wb);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(7827));
        rst         = 1'b1;
        start       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = CMD_NOP;
        idx         = '0;
        step        = '0;
        mem_rdata32 = '0;
        mem_rdata64 = '0;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < rows.size(); n++) begin
            // No idle gap between the two halves of FSTP m64
            if (!(rows[n].cmd == CMD_FSTP_M64 && rows[n].step[0])) begin
                repeat ($urandom % 3) @(posedge clk);
            end
            apply_row(rows[n]);
            expect_results(rows[n]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: x87_exec.f
+incdir+testbench
hw/x87_pkg.sv
hw/x87_request_in.sv
hw/x87_reg_stack.sv
hw/x87_control_regs.sv
hw/x87_store_out.sv
hw/x87_exec.sv
testbench/tb_x87_exec.sv

// File: Makefile
TOP = tb_x87_exec

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f x87_exec.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
		echo "$$out"; \
		echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
